//--- source/glue_consts.svh
// ------------------------------
// address windows, config bit positions
// and reset hold length
// ------------------------------
`ifndef GLUE_CONSTS_SVH
`define GLUE_CONSTS_SVH

// sof pulses the system reset is held for
`define GLUE_RESET_FRAMES   4

// address pages, bits 23..16
`define GLUE_CIA_PAGE       8'hBF
`define GLUE_RTC_PAGE       8'hDC

// top address bits that must be zero for chip ram, first 2 MB
`define GLUE_CHIP_TOP_BITS  3

// chipset config bits
`define GLUE_CFG_NTSC       1
`define GLUE_CFG_AGA        4

// cpu config bits
`define GLUE_CFG_FASTCHIP   2
`define GLUE_CFG_FASTKICK   3

`endif

//--- source/glue_pkg.sv
// ------------------------------
// shared vector typedefs, reset state enum
// read-select and system-control interfaces
// ------------------------------
`default_nettype none

package glue_pkg;

  typedef logic [23:1] cpu_addr_t;  // cpu word address
  typedef logic [15:0] word_t;      // data bus word
  typedef logic [7:0]  byte_t;      // cia data byte
  typedef logic [63:0] rtc_t;       // sixteen packed rtc nibbles
  typedef logic [3:0]  rtc_idx_t;   // nibble index into rtc_t
  typedef logic [6:0]  mem_cfg_t;   // chip, slow, fast size, monitor
  typedef logic [4:0]  chip_cfg_t;  // ntsc, a1000, ecs, aga
  typedef logic [3:0]  cpu_cfg_t;   // fast chip, fast kick in top bits
  typedef logic [2:0]  ipl_t;       // active low interrupt level

  // reset sequencer states
  typedef enum logic [1:0] {
    RST_HOLD,   // a source is still active
    RST_COUNT,  // counting start-of-frame pulses
    RST_RUN     // system released
  } rst_state_t;

endpackage

// decoder to read result, one window select at a time
interface rd_sel_if;
  logic                rd;         // qualified read strobe
  logic                sel_chip;
  logic                sel_cia_a;
  logic                sel_cia_b;
  logic                sel_rtc;
  glue_pkg::rtc_idx_t  rtc_idx;

  modport decoder (output rd, sel_chip, sel_cia_a, sel_cia_b, sel_rtc, rtc_idx);
  modport result  (input  rd, sel_chip, sel_cia_a, sel_cia_b, sel_rtc, rtc_idx);
endinterface

// reset sequencer to config block
interface sys_ctl_if;
  logic sys_reset;   // held system reset
  logic glob_reset;  // sys_reset or cpu reset
  logic clk7_en;
  logic sof;

  modport source (output sys_reset, glob_reset, clk7_en, sof);
  modport sink   (input  sys_reset, glob_reset, clk7_en, sof);
endinterface

`default_nettype wire

//--- source/glue_decode.sv
// ------------------------------
// cpu address window decoder
// ------------------------------
`default_nettype none

`include "glue_consts.svh"

module glue_decode import glue_pkg::*; (
  input  wire cpu_addr_t addr_i,
  input  wire logic      rd_i,
  rd_sel_if.decoder      sel
);

  logic [7:0] page;      // address bits 23..16
  logic       cia_page;
  logic       rtc_page;
  logic       chip_hit;

  assign page     = addr_i[23:16];
  assign cia_page = (page == `GLUE_CIA_PAGE);
  assign rtc_page = (page == `GLUE_RTC_PAGE);

  // chip ram lives below the first set top bit
  assign chip_hit = (addr_i[23 -: `GLUE_CHIP_TOP_BITS] == '0);

  assign sel.rd       = rd_i;
  assign sel.sel_chip = chip_hit;

  // cia a on a12 low, cia b on a13 low
  // both low is cia a only
  assign sel.sel_cia_a = cia_page & ~addr_i[12];
  assign sel.sel_cia_b = cia_page & addr_i[12] & ~addr_i[13];

  assign sel.sel_rtc = rtc_page;
  assign sel.rtc_idx = addr_i[5:2];  // one nibble per long word

  // page compares and the chip range must never overlap
  always_comb begin
    assert ($onehot0({sel.sel_chip, sel.sel_cia_a, sel.sel_cia_b, sel.sel_rtc}))
      else $error("decode: more than one window selected");
  end

endmodule

`default_nettype wire

//--- source/glue_reset_ctrl.sv
// ------------------------------
// reset source merge
// frame counting reset sequencer
// ------------------------------
`default_nettype none

`include "glue_consts.svh"

module glue_reset_ctrl import glue_pkg::*; (
  input  wire logic clk,
  input  wire logic reset,
  input  wire logic clk7_en_i,
  input  wire logic sof_i,
  input  wire logic cpu_reset_n_i,
  input  wire logic kbd_reset_n_i,
  input  wire logic usr_reset_i,
  output logic      sys_reset_o,
  output logic      cpu_reset_n_o,
  output logic      rst_out_o,
  sys_ctl_if.source ctl
);

  localparam int CNT_W = $clog2(`GLUE_RESET_FRAMES + 1);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`GLUE_RESET_FRAMES - 1);

  rst_state_t       state;
  rst_state_t       state_nxt;
  logic [CNT_W-1:0] frame_cnt;
  logic             src_req;     // any reset source active
  logic             frame_tick;  // qualified sof pulse
  logic             sys_reset_q;

  assign src_req    = usr_reset_i | ~kbd_reset_n_i;
  assign frame_tick = ctl.clk7_en & ctl.sof;

  always_comb begin
    state_nxt = state;
    case (state)
      RST_HOLD:  state_nxt = RST_COUNT;                 // sources gone
      RST_COUNT: if (frame_tick && frame_cnt == CNT_LAST) state_nxt = RST_RUN;
      default:   state_nxt = RST_RUN;
    endcase
    if (src_req) state_nxt = RST_HOLD;                  // any source restarts
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= RST_HOLD;
      frame_cnt   <= '0;
      sys_reset_q <= 1'b1;
    end else begin
      state       <= state_nxt;
      sys_reset_q <= (state_nxt != RST_RUN);  // registered with the state
      if (state != RST_COUNT || src_req)
        frame_cnt <= '0;
      else if (frame_tick)
        frame_cnt <= (frame_cnt == CNT_LAST) ? '0 : frame_cnt + 1'b1;
    end
  end

  assign ctl.clk7_en    = clk7_en_i;
  assign ctl.sof        = sof_i;
  assign ctl.sys_reset  = sys_reset_q;
  assign ctl.glob_reset = sys_reset_q | ~cpu_reset_n_i;  // cpu may hold it longer

  assign sys_reset_o   = sys_reset_q;
  assign cpu_reset_n_o = ~sys_reset_q;
  assign rst_out_o     = ctl.glob_reset;

  // counter stays inside the hold window
  a_cnt_range: assert property (@(posedge clk) disable iff (reset)
    frame_cnt <= CNT_LAST);

  // system held until the sequencer runs
  a_hold: assert property (@(posedge clk) disable iff (reset)
    (state != RST_RUN) |-> sys_reset_o);

endmodule

`default_nettype wire

//--- source/glue_sysconfig.sv
// ------------------------------
// config capture and derived outputs
// ntsc latch, mcu vsync toggle, power led
// ------------------------------
`default_nettype none

`include "glue_consts.svh"

module glue_sysconfig import glue_pkg::*; (
  input  wire logic      clk,
  input  wire logic      reset,
  input  wire logic      vsync_n_i,
  input  wire logic      hblank_i,
  input  wire mem_cfg_t  mem_cfg_i,
  input  wire chip_cfg_t chip_cfg_i,
  input  wire cpu_cfg_t  cpu_cfg_i,
  input  wire logic      ovl_i,
  input  wire logic      led_n_i,
  input  wire logic      led_dim_n_i,
  sys_ctl_if.sink        ctl,
  output logic           ntsc_o,
  output logic           init_b_o,
  output logic           pwr_led_o,
  output logic           turbochipram_o,
  output logic           turbokick_o,
  output logic           aga_o,
  output logic [1:0]     slow_cfg_o,
  output cpu_cfg_t       cpu_cfg_o
);

  mem_cfg_t  mem_cfg_q;
  chip_cfg_t chip_cfg_q;
  cpu_cfg_t  cpu_cfg_q;
  logic      ovl_q;
  logic      ntsc_q;
  logic      vsync_del;   // vsync seen on the last clk7 enable
  logic      vsync_tgl;

  // ------------------------------
  // config copies, one clock behind
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      mem_cfg_q  <= '0;
      chip_cfg_q <= '0;
      cpu_cfg_q  <= '0;
      ovl_q      <= 1'b0;
    end else begin
      mem_cfg_q  <= mem_cfg_i;
      chip_cfg_q <= chip_cfg_i;
      cpu_cfg_q  <= cpu_cfg_i;
      ovl_q      <= ovl_i;
    end
  end

  assign aga_o      = chip_cfg_q[`GLUE_CFG_AGA];
  assign slow_cfg_o = mem_cfg_q[3:2];
  assign cpu_cfg_o  = cpu_cfg_q;

  // fast chip needs aga, no overlay and 2 MB chip
  assign turbochipram_o = aga_o & ~ovl_q & cpu_cfg_q[`GLUE_CFG_FASTCHIP]
                        & (&mem_cfg_q[1:0]);
  assign turbokick_o    = aga_o & ~ovl_q & cpu_cfg_q[`GLUE_CFG_FASTKICK];

  // pal/ntsc only changes under reset
  always_ff @(posedge clk) begin
    if (ctl.glob_reset && ctl.clk7_en)
      ntsc_q <= chip_cfg_q[`GLUE_CFG_NTSC];
  end
  assign ntsc_o = ntsc_q;

  // ------------------------------
  // mcu vsync toggle
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      vsync_del <= 1'b0;
    end else if (ctl.clk7_en) begin
      vsync_del <= vsync_n_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || ctl.sys_reset) begin
      vsync_tgl <= 1'b0;                            // held low through the sequence
    end else if (ctl.clk7_en && vsync_del && !vsync_n_i) begin
      vsync_tgl <= ~vsync_tgl;                      // falling vsync
    end
  end
  assign init_b_o = vsync_tgl;

  // dimmed led is off only outside hblank
  assign pwr_led_o = led_dim_n_i ? ~led_n_i : ~(led_n_i & ~hblank_i);

  // fast kick only on an aga config seen one clock earlier
  a_kick_aga: assert property (@(posedge clk) disable iff (reset)
    turbokick_o |-> $past(chip_cfg_i[`GLUE_CFG_AGA]));

endmodule

`default_nettype wire

//--- source/glue_read_result.sv
// ------------------------------
// registered cpu read word
// rtc nibble select, level 7 override
// ------------------------------
`default_nettype none

module glue_read_result import glue_pkg::*; (
  input  wire logic  clk,
  input  wire logic  reset,
  input  wire word_t chip_data_i,
  input  wire byte_t cia_a_data_i,
  input  wire byte_t cia_b_data_i,
  input  wire rtc_t  rtc_i,
  input  wire logic  int7_i,
  input  wire ipl_t  ipl_n_i,
  rd_sel_if.result   sel,
  output word_t      data_o,
  output ipl_t       ipl_n_o
);

  word_t      chip_word;
  word_t      cia_word;
  word_t      rtc_word;
  logic [3:0] rtc_nib;
  word_t      data_q;

  assign rtc_nib = rtc_i[{sel.rtc_idx, 2'b00} +: 4];

  // each source is zero unless selected, so they OR together
  assign chip_word = sel.sel_chip ? chip_data_i : '0;
  assign cia_word  = (sel.sel_cia_a ? {8'h00, cia_a_data_i} : '0)   // low lane
                   | (sel.sel_cia_b ? {cia_b_data_i, 8'h00} : '0);  // high lane
  assign rtc_word  = sel.sel_rtc ? {12'h000, rtc_nib} : '0;

  always_ff @(posedge clk) begin
    if (reset || !sel.rd) begin
      data_q <= '0;
    end else begin
      data_q <= chip_word | cia_word | rtc_word;
    end
  end

  assign data_o = data_q;

  // nmi wins over the audio/disk chip levels
  assign ipl_n_o = int7_i ? 3'b000 : ipl_n_i;

  // idle cycle or a read outside every window gives a zero word
  a_idle_zero: assert property (@(posedge clk) disable iff (reset)
    !(sel.rd && (sel.sel_chip || sel.sel_cia_a || sel.sel_cia_b || sel.sel_rtc))
    |=> (data_o == '0));

endmodule

`default_nettype wire

//--- source/minimig_glue.sv
// ------------------------------
// chipset glue top level
// decode, reset, config and read result wiring
// ------------------------------
`default_nettype none

module minimig_glue import glue_pkg::*; (
  input  wire logic      clk,
  input  wire logic      reset,
  input  wire logic      clk7_en_i,      // 7 MHz enable
  input  wire logic      sof_i,          // start of frame
  input  wire logic      vsync_n_i,
  input  wire logic      hblank_i,
  input  wire logic      cpu_reset_n_i,
  input  wire logic      kbd_reset_n_i,
  input  wire logic      usr_reset_i,    // osd reset
  input  wire cpu_addr_t addr_i,
  input  wire logic      rd_i,
  input  wire word_t     chip_data_i,
  input  wire byte_t     cia_a_data_i,
  input  wire byte_t     cia_b_data_i,
  input  wire rtc_t      rtc_i,
  input  wire mem_cfg_t  mem_cfg_i,
  input  wire chip_cfg_t chip_cfg_i,
  input  wire cpu_cfg_t  cpu_cfg_i,
  input  wire logic      ovl_i,          // kickstart overlay
  input  wire logic      led_n_i,
  input  wire logic      led_dim_n_i,
  input  wire logic      int7_i,
  input  wire ipl_t      ipl_n_i,        // from the audio/disk chip
  output word_t          data_o,
  output ipl_t           ipl_n_o,
  output logic           sys_reset_o,
  output logic           cpu_reset_n_o,
  output logic           rst_out_o,
  output logic           ntsc_o,
  output logic           init_b_o,       // vsync toggle for the mcu
  output logic           pwr_led_o,
  output logic           turbochipram_o,
  output logic           turbokick_o,
  output logic           aga_o,
  output logic [1:0]     slow_cfg_o,
  output cpu_cfg_t       cpu_cfg_o
);

  rd_sel_if  rd_sel ();
  sys_ctl_if sys_ctl ();

  // ------------------------------
  // decode
  // ------------------------------
  glue_decode u_decode (
    .addr_i (addr_i),
    .rd_i   (rd_i),
    .sel    (rd_sel.decoder)
  );

  // ------------------------------
  // execute
  // ------------------------------
  glue_reset_ctrl u_reset_ctrl (
    .clk           (clk),
    .reset         (reset),
    .clk7_en_i     (clk7_en_i),
    .sof_i         (sof_i),
    .cpu_reset_n_i (cpu_reset_n_i),
    .kbd_reset_n_i (kbd_reset_n_i),
    .usr_reset_i   (usr_reset_i),
    .sys_reset_o   (sys_reset_o),
    .cpu_reset_n_o (cpu_reset_n_o),
    .rst_out_o     (rst_out_o),
    .ctl           (sys_ctl.source)
  );

  glue_sysconfig u_sysconfig (
    .clk            (clk),
    .reset          (reset),
    .vsync_n_i      (vsync_n_i),
    .hblank_i       (hblank_i),
    .mem_cfg_i      (mem_cfg_i),
    .chip_cfg_i     (chip_cfg_i),
    .cpu_cfg_i      (cpu_cfg_i),
    .ovl_i          (ovl_i),
    .led_n_i        (led_n_i),
    .led_dim_n_i    (led_dim_n_i),
    .ctl            (sys_ctl.sink),
    .ntsc_o         (ntsc_o),
    .init_b_o       (init_b_o),
    .pwr_led_o      (pwr_led_o),
    .turbochipram_o (turbochipram_o),
    .turbokick_o    (turbokick_o),
    .aga_o          (aga_o),
    .slow_cfg_o     (slow_cfg_o),
    .cpu_cfg_o      (cpu_cfg_o)
  );

  // ------------------------------
  // result
  // ------------------------------
  glue_read_result u_read_result (
    .clk          (clk),
    .reset        (reset),
    .chip_data_i  (chip_data_i),
    .cia_a_data_i (cia_a_data_i),
    .cia_b_data_i (cia_b_data_i),
    .rtc_i        (rtc_i),
    .int7_i       (int7_i),
    .ipl_n_i      (ipl_n_i),
    .sel          (rd_sel.result),
    .data_o       (data_o),
    .ipl_n_o      (ipl_n_o)
  );

endmodule

`default_nettype wire

//--- sim/tb_minimig_glue.sv
// ------------------------------
// testbench for the chipset glue top level
// random stimulus, cycle model, checks, watchdog
// ------------------------------
`default_nettype none

`include "glue_consts.svh"

module tb_minimig_glue import glue_pkg::*; ();

  localparam int CLK_PERIOD      = 40;
  localparam int RESET_CYCLES    = 4;
  localparam int RUN_CYCLES      = 4000;
  localparam int WATCHDOG_CYCLES = RUN_CYCLES + RUN_CYCLES / 8;  // 4500
  localparam logic [31:0] SEED   = 32'h23d7_21ea;
  localparam int M_HOLD  = 0;  // model reset states
  localparam int M_COUNT = 1;
  localparam int M_RUN   = 2;

  // dut inputs
  logic      clk;
  logic      reset;
  logic      clk7_en;
  logic      sof;
  logic      vsync_n;
  logic      hblank;
  logic      cpu_reset_n;
  logic      kbd_reset_n;
  logic      usr_reset;
  cpu_addr_t addr;
  logic      rd;
  word_t     chip_data;
  byte_t     cia_a_data;
  byte_t     cia_b_data;
  rtc_t      rtc;
  mem_cfg_t  mem_cfg;
  chip_cfg_t chip_cfg;
  cpu_cfg_t  cpu_cfg;
  logic      ovl;
  logic      led_n;
  logic      led_dim_n;
  logic      int7;
  ipl_t      ipl_n;

  // dut outputs
  word_t      data;
  ipl_t       ipl_out;
  logic       sys_reset;
  logic       cpu_reset_n_out;
  logic       rst_out;
  logic       ntsc;
  logic       init_b;
  logic       pwr_led;
  logic       turbochipram;
  logic       turbokick;
  logic       aga;
  logic [1:0] slow_cfg;
  cpu_cfg_t   cpu_cfg_out;

  // model state
  int        m_state;
  int        m_cnt;
  logic      m_sys_reset;
  mem_cfg_t  m_mem_q;
  chip_cfg_t m_chip_q;
  cpu_cfg_t  m_cpu_q;
  logic      m_ovl_q;
  logic      m_ntsc;
  logic      m_ntsc_known;  // latch loaded at least once
  logic      m_vs_del;
  logic      m_tgl;
  word_t     m_data;
  int        releases;      // completed reset sequences
  int        cyc;
  logic [31:0] seed_ret;

  minimig_glue dut (
    .clk (clk), .reset (reset), .clk7_en_i (clk7_en), .sof_i (sof),
    .vsync_n_i (vsync_n), .hblank_i (hblank), .cpu_reset_n_i (cpu_reset_n),
    .kbd_reset_n_i (kbd_reset_n), .usr_reset_i (usr_reset), .addr_i (addr),
    .rd_i (rd), .chip_data_i (chip_data), .cia_a_data_i (cia_a_data),
    .cia_b_data_i (cia_b_data), .rtc_i (rtc), .mem_cfg_i (mem_cfg),
    .chip_cfg_i (chip_cfg), .cpu_cfg_i (cpu_cfg), .ovl_i (ovl), .led_n_i (led_n),
    .led_dim_n_i (led_dim_n), .int7_i (int7), .ipl_n_i (ipl_n),
    .data_o (data), .ipl_n_o (ipl_out), .sys_reset_o (sys_reset),
    .cpu_reset_n_o (cpu_reset_n_out), .rst_out_o (rst_out), .ntsc_o (ntsc),
    .init_b_o (init_b), .pwr_led_o (pwr_led), .turbochipram_o (turbochipram),
    .turbokick_o (turbokick), .aga_o (aga), .slow_cfg_o (slow_cfg),
    .cpu_cfg_o (cpu_cfg_out)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // expected read word for one address, from the window rules
  function automatic word_t expect_read(cpu_addr_t a);
    word_t      w;
    logic [7:0] page;
    w    = '0;
    page = a[23:16];
    if ((a >> (23 - `GLUE_CHIP_TOP_BITS)) == '0) w = chip_data;
    if (page == `GLUE_CIA_PAGE) begin
      if (!a[12])      w = {8'h00, cia_a_data};  // cia a wins
      else if (!a[13]) w = {cia_b_data, 8'h00};
    end
    if (page == `GLUE_RTC_PAGE) w = {12'h000, 4'(rtc >> {a[5:2], 2'b00})};
    return w;
  endfunction

  // ------------------------------
  // cycle model, old input values
  // ------------------------------
  task automatic step_model();
    int   nxt;
    logic src;
    logic tick;
    logic glob;
    src  = usr_reset | ~kbd_reset_n;
    tick = clk7_en & sof;
    glob = m_sys_reset | ~cpu_reset_n;
    if (glob && clk7_en) begin    // latch loads under top reset too
      m_ntsc       = m_chip_q[`GLUE_CFG_NTSC];
      m_ntsc_known = 1'b1;
    end
    if (reset) begin
      m_state     = M_HOLD;
      m_cnt       = 0;
      m_sys_reset = 1'b1;
      m_mem_q     = '0;
      m_chip_q    = '0;
      m_cpu_q     = '0;
      m_ovl_q     = 1'b0;
      m_vs_del    = 1'b0;
      m_tgl       = 1'b0;
      m_data      = '0;
    end else begin
      nxt = m_state;
      if (m_state == M_HOLD) nxt = M_COUNT;
      else if (m_state == M_COUNT && tick && m_cnt == `GLUE_RESET_FRAMES - 1) nxt = M_RUN;
      if (src) nxt = M_HOLD;
      if (m_sys_reset) m_tgl = 1'b0;
      else if (clk7_en && m_vs_del && !vsync_n) m_tgl = ~m_tgl;
      if (clk7_en) m_vs_del = vsync_n;
      if (m_state != M_COUNT || src) m_cnt = 0;
      else if (tick) m_cnt = (m_cnt == `GLUE_RESET_FRAMES - 1) ? 0 : m_cnt + 1;
      if (m_sys_reset && nxt == M_RUN) releases++;
      m_state     = nxt;
      m_sys_reset = (nxt != M_RUN);
      m_mem_q     = mem_cfg;
      m_chip_q    = chip_cfg;
      m_cpu_q     = cpu_cfg;
      m_ovl_q     = ovl;
      m_data      = rd ? expect_read(addr) : '0;
    end
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    logic [31:0] lo;
    logic [31:0] d;
    r  = $urandom();
    lo = $urandom();
    d  = $urandom();
    clk7_en     <= (cyc % 4 == 3);
    sof         <= ($urandom() % 8 == 0);
    usr_reset   <= ($urandom() % 700 == 0);  // rare reset sources
    kbd_reset_n <= ($urandom() % 700 != 0);
    cpu_reset_n <= ($urandom() % 64 != 0);
    if ($urandom() % 16 == 0) vsync_n <= ~vsync_n;
    case (r[1:0])                            // page bias
      2'd0:    addr <= {`GLUE_CIA_PAGE, lo[14:0]};
      2'd1:    addr <= {`GLUE_RTC_PAGE, lo[14:0]};
      2'd2:    addr <= {3'b000, lo[19:0]};
      default: addr <= lo[22:0];
    endcase
    rd         <= r[2] | r[3];
    chip_data  <= d[15:0];
    cia_a_data <= d[23:16];
    cia_b_data <= d[31:24];
    rtc        <= {$urandom(), $urandom()};
    mem_cfg    <= r[10:4];
    chip_cfg   <= r[15:11];
    cpu_cfg    <= r[19:16];
    ovl        <= r[20];
    hblank     <= r[21];
    led_n      <= r[22];
    led_dim_n  <= r[23];
    int7       <= r[24] & r[25];
    ipl_n      <= r[28:26];
    cyc++;
  endtask

  // stimulus stream, seeded in its own process
  initial begin
    seed_ret = $urandom(SEED);
    forever begin
      @(posedge clk);
      step_model();
      drive_inputs();
    end
  end

  // ------------------------------
  // checks on the falling edge
  // ------------------------------
  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, what, got, exp);
      $display("TEST FAIL");
      $fatal(1, "output check failed");
    end
  endtask

  task automatic run_checks();
    logic exp_led;
    logic exp_tcr;
    if (led_dim_n) exp_led = !led_n;
    else if (led_n && !hblank) exp_led = 1'b0;  // dimmed, off outside hblank
    else exp_led = 1'b1;
    exp_tcr = m_chip_q[`GLUE_CFG_AGA] && !m_ovl_q && m_cpu_q[`GLUE_CFG_FASTCHIP]
              && m_mem_q[1] && m_mem_q[0];
    check_value("data_o", 64'(data), 64'(m_data));
    check_value("sys_reset_o", 64'(sys_reset), 64'(m_sys_reset));
    check_value("cpu_reset_n_o", 64'(cpu_reset_n_out), 64'(!m_sys_reset));
    check_value("rst_out_o", 64'(rst_out), 64'(m_sys_reset || !cpu_reset_n));
    check_value("turbochipram_o", 64'(turbochipram), 64'(exp_tcr));
    check_value("turbokick_o", 64'(turbokick), 64'(m_chip_q[`GLUE_CFG_AGA] && !m_ovl_q
                && m_cpu_q[`GLUE_CFG_FASTKICK]));
    check_value("aga_o", 64'(aga), 64'(m_chip_q[`GLUE_CFG_AGA]));
    check_value("slow_cfg_o", 64'(slow_cfg), 64'(m_mem_q[3:2]));
    check_value("cpu_cfg_o", 64'(cpu_cfg_out), 64'(m_cpu_q));
    if (m_ntsc_known) check_value("ntsc_o", 64'(ntsc), 64'(m_ntsc));
    check_value("init_b_o", 64'(init_b), 64'(m_tgl));
    check_value("pwr_led_o", 64'(pwr_led), 64'(exp_led));
    check_value("ipl_n_o", 64'(ipl_out), 64'(int7 ? 3'b000 : ipl_n));
  endtask

  always @(negedge clk) begin
    if (!reset) run_checks();
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired, the run did not finish in time");
    $display("TEST FAIL");
    $fatal(1, "timeout");
  end

  initial begin
    reset        = 1'b1;
    clk7_en      = 1'b0;  // no enable on the first edge
    sof          = 1'b0;
    vsync_n      = 1'b1;
    hblank       = 1'b0;
    cpu_reset_n  = 1'b1;
    kbd_reset_n  = 1'b1;
    usr_reset    = 1'b0;
    addr         = '0;
    rd           = 1'b0;
    chip_data    = '0;
    cia_a_data   = '0;
    cia_b_data   = '0;
    rtc          = '0;
    mem_cfg      = '0;
    chip_cfg     = '0;
    cpu_cfg      = '0;
    ovl          = 1'b0;
    led_n        = 1'b1;
    led_dim_n    = 1'b1;
    int7         = 1'b0;
    ipl_n        = 3'b111;
    m_state      = M_HOLD;
    m_cnt        = 0;
    m_sys_reset  = 1'b1;
    m_ntsc       = 1'b0;
    m_ntsc_known = 1'b0;
    releases     = 0;
    cyc          = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    repeat (RUN_CYCLES) @(posedge clk);
    @(negedge clk);
    if (releases < 2) begin
      $display("reset sequence completed only %0d times", releases);
      $display("TEST FAIL");
      $fatal(1, "too few reset sequences");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+source
source/glue_pkg.sv
source/glue_decode.sv
source/glue_reset_ctrl.sv
source/glue_sysconfig.sv
source/glue_read_result.sv
source/minimig_glue.sv
sim/tb_minimig_glue.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the glue testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  -f src.f \
  --top-module tb_minimig_glue \
  -Mdir obj_dir \
  -o Vtb_minimig_glue

# exit status is non-zero on any $fatal
./obj_dir/Vtb_minimig_glue
